// File: controlPkg.sv
package controlPkg;

	// Instruction fields
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;

	// Datapath selectors
	typedef logic [1:0] aluSrcAT;
	typedef logic [2:0] aluSrcBT;
	typedef logic [2:0] aluOpT;
	typedef logic [2:0] pcSourceT;
	typedef logic [2:0] shiftCtrlT;
	typedef logic [2:0] regDstT;
	typedef logic [3:0] memToRegT;

	typedef enum logic [6:0] {
		stFetch      = 7'd0,
		stWaitFetch  = 7'd1,
		stWaitFetch2 = 7'd2,
		stDecode     = 7'd3,
		stExecute    = 7'd4,
		stWriteBack  = 7'd5,
		stIdle       = 7'd127
	} controlStateT;

	typedef enum logic [3:0] {
		clsAddi,
		clsAddiu,
		clsLui,
		clsAdd,
		clsSub,
		clsAnd,
		clsSrl,
		clsSra,
		clsBreak,
		clsUnsupported
	} instrClassT;

	localparam opcodeT opRType = 6'd0;
	localparam opcodeT opAddi  = 6'd8;
	localparam opcodeT opAddiu = 6'd9;
	localparam opcodeT opLui   = 6'd15;

	localparam functT fnAdd   = 6'd32;
	localparam functT fnSub   = 6'd34;
	localparam functT fnAnd   = 6'd36;
	localparam functT fnSrl   = 6'd2;
	localparam functT fnSra   = 6'd3;
	localparam functT fnBreak = 6'd13;

	localparam aluOpT aluNone = 3'd0;
	localparam aluOpT aluAdd  = 3'd1;
	localparam aluOpT aluSub  = 3'd2;
	localparam aluOpT aluAnd  = 3'd3;

	localparam aluSrcAT srcARegA = 2'd2;

	localparam aluSrcBT srcBRegB   = 3'd0;
	localparam aluSrcBT srcBFour   = 3'd1;
	localparam aluSrcBT srcBImm    = 3'd2;
	localparam aluSrcBT srcBBranch = 3'd4;

	localparam pcSourceT pcFromAlu = 3'd1;

	localparam shiftCtrlT shiftLoad  = 3'd1;
	localparam shiftCtrlT shiftRight = 3'd3;
	localparam shiftCtrlT shiftArith = 3'd4;

	localparam regDstT regDstRt  = 3'd0;
	localparam regDstT regDstImm = 3'd2;
	localparam regDstT regDstRd  = 3'd5;

	localparam memToRegT memToRegShift = 4'd3;
	localparam memToRegT memToRegAlu   = 4'd8;
	localparam memToRegT memToRegUpper = 4'd10;

endpackage

// File: instructionDecoder.sv
`timescale 1ns/100ps

module instructionDecoder (
	input  controlPkg::opcodeT     opcode,
	input  controlPkg::functT      funct,
	output controlPkg::instrClassT instrClass
);

	import controlPkg::*;

	// R-type instructions are told apart by funct
	instrClassT rTypeClass;

	always_comb begin
		case (funct)
			fnAdd: begin
				rTypeClass = clsAdd;
			end
			fnSub: begin
				rTypeClass = clsSub;
			end
			fnAnd: begin
				rTypeClass = clsAnd;
			end
			fnSrl: begin
				rTypeClass = clsSrl;
			end
			fnSra: begin
				rTypeClass = clsSra;
			end
			fnBreak: begin
				rTypeClass = clsBreak;
			end
			default: begin
				rTypeClass = clsUnsupported;
			end
		endcase
	end

	always_comb begin
		case (opcode)
			opRType: begin
				instrClass = rTypeClass;
			end
			opAddi: begin
				instrClass = clsAddi;
			end
			opAddiu: begin
				instrClass = clsAddiu;
			end
			opLui: begin
				instrClass = clsLui;
			end
			default: begin
				instrClass = clsUnsupported;
			end
		endcase
	end

endmodule

// File: controlSequencer.sv
`timescale 1ns/100ps

module controlSequencer (
	input                          clock,
	input                          reset,
	input  controlPkg::instrClassT instrClass,
	output controlPkg::controlStateT state,
	output controlPkg::instrClassT latchedClass
);

	import controlPkg::*;

	controlStateT nextState;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= stFetch;
			latchedClass <= clsUnsupported;
		end else begin
			state <= nextState;
			// Opcode and funct are only trusted in decode
			if (state == stDecode) begin
				latchedClass <= instrClass;
			end
		end
	end

	always_comb begin
		case (state)
			stFetch: begin
				nextState = stWaitFetch;
			end
			stWaitFetch: begin
				nextState = stWaitFetch2;
			end
			stWaitFetch2: begin
				nextState = stDecode;
			end
			stDecode: begin
				nextState = stExecute;
			end
			stExecute: begin
				case (latchedClass)
					clsAddi, clsAddiu, clsAdd, clsSub, clsAnd, clsSrl, clsSra: begin
						nextState = stWriteBack;
					end
					clsBreak: begin
						nextState = stFetch;
					end
					default: begin
						// LUI writes in execute, unsupported does nothing
						nextState = stIdle;
					end
				endcase
			end
			stWriteBack: begin
				nextState = stIdle;
			end
			stIdle: begin
				nextState = stFetch;
			end
			default: begin
				nextState = stFetch;
			end
		endcase
	end

endmodule

// File: controlSignalTable.sv
`timescale 1ns/100ps

module controlSignalTable (
	input  controlPkg::controlStateT state,
	input  controlPkg::instrClassT   latchedClass,
	output logic                     pcWrite,
	output logic                     regWrite,
	output logic                     irWrite,
	output logic                     writeRegA,
	output logic                     writeRegB,
	output logic                     aluOutControl,
	output logic                     shiftSrc,
	output logic                     shiftAmt,
	output controlPkg::aluSrcAT      aluSrcA,
	output controlPkg::aluSrcBT      aluSrcB,
	output controlPkg::aluOpT        aluOp,
	output controlPkg::pcSourceT     pcSource,
	output controlPkg::shiftCtrlT    shiftCtrl,
	output controlPkg::regDstT       regDst,
	output controlPkg::memToRegT     memToReg
);

	import controlPkg::*;

	always_comb begin
		// Everything inactive unless a state sets it
		pcWrite = 1'b0;
		regWrite = 1'b0;
		irWrite = 1'b0;
		writeRegA = 1'b0;
		writeRegB = 1'b0;
		aluOutControl = 1'b0;
		shiftSrc = 1'b0;
		shiftAmt = 1'b0;
		aluSrcA = '0;
		aluSrcB = '0;
		aluOp = aluNone;
		pcSource = '0;
		shiftCtrl = '0;
		regDst = '0;
		memToReg = '0;

		case (state)
			stFetch: begin
				// PC + 4
				pcWrite = 1'b1;
				aluSrcB = srcBFour;
				aluOp = aluAdd;
				pcSource = pcFromAlu;
				regDst = regDstRd;
			end
			stWaitFetch2: begin
				irWrite = 1'b1;
			end
			stDecode: begin
				irWrite = 1'b1;
				writeRegA = 1'b1;
				writeRegB = 1'b1;
				// Branch target computed ahead of time
				aluOutControl = 1'b1;
				aluSrcB = srcBBranch;
				aluOp = aluAdd;
				shiftSrc = 1'b1;
				shiftCtrl = shiftLoad;
			end
			stExecute: begin
				case (latchedClass)
					clsAddi, clsAddiu: begin
						aluSrcA = srcARegA;
						aluSrcB = srcBImm;
						aluOp = aluAdd;
						aluOutControl = 1'b1;
						regDst = (latchedClass == clsAddi) ? regDstImm : regDstRt;
					end
					clsAdd, clsSub, clsAnd: begin
						aluSrcA = srcARegA;
						aluSrcB = srcBRegB;
						aluOutControl = 1'b1;
						if (latchedClass == clsSub) begin
							aluOp = aluSub;
						end else if (latchedClass == clsAnd) begin
							aluOp = aluAnd;
						end else begin
							aluOp = aluAdd;
						end
					end
					clsSrl: begin
						shiftAmt = 1'b1;
						shiftCtrl = shiftRight;
					end
					clsSra: begin
						shiftAmt = 1'b1;
						shiftCtrl = shiftArith;
					end
					clsLui: begin
						regWrite = 1'b1;
						regDst = regDstImm;
						memToReg = memToRegUpper;
					end
					clsBreak: begin
						pcWrite = 1'b1;
						aluSrcB = srcBFour;
						aluOp = aluSub;
						pcSource = pcFromAlu;
					end
					default: begin
						// Unsupported code, nothing driven
					end
				endcase
			end
			stWriteBack: begin
				case (latchedClass)
					clsAddi, clsAddiu: begin
						regWrite = 1'b1;
						regDst = regDstImm;
						memToReg = memToRegAlu;
					end
					clsAdd, clsSub, clsAnd: begin
						regWrite = 1'b1;
						regDst = regDstRd;
						memToReg = memToRegAlu;
					end
					clsSrl, clsSra: begin
						regWrite = 1'b1;
						regDst = regDstRd;
						memToReg = memToRegShift;
					end
					default: begin
					end
				endcase
			end
			default: begin
				// Wait states and idle leave all outputs low
			end
		endcase
	end

endmodule

// File: controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
	input                            clock,
	input                            reset,
	input  controlPkg::opcodeT       opcode,
	input  controlPkg::functT        funct,
	output logic                     pcWrite,
	output logic                     regWrite,
	output logic                     irWrite,
	output logic                     writeRegA,
	output logic                     writeRegB,
	output logic                     aluOutControl,
	output logic                     shiftSrc,
	output logic                     shiftAmt,
	output controlPkg::aluSrcAT      aluSrcA,
	output controlPkg::aluSrcBT      aluSrcB,
	output controlPkg::aluOpT        aluOp,
	output controlPkg::pcSourceT     pcSource,
	output controlPkg::shiftCtrlT    shiftCtrl,
	output controlPkg::regDstT       regDst,
	output controlPkg::memToRegT     memToReg,
	output controlPkg::controlStateT state
);

	import controlPkg::*;

	instrClassT instrClass;
	instrClassT latchedClass;

	instructionDecoder instructionDecoder_inst (
		.opcode     (opcode),
		.funct      (funct),
		.instrClass (instrClass)
	);

	// Class is held from decode until the next decode
	controlSequencer controlSequencer_inst (
		.clock        (clock),
		.reset        (reset),
		.instrClass   (instrClass),
		.state        (state),
		.latchedClass (latchedClass)
	);

	controlSignalTable controlSignalTable_inst (
		.state         (state),
		.latchedClass  (latchedClass),
		.pcWrite       (pcWrite),
		.regWrite      (regWrite),
		.irWrite       (irWrite),
		.writeRegA     (writeRegA),
		.writeRegB     (writeRegB),
		.aluOutControl (aluOutControl),
		.shiftSrc      (shiftSrc),
		.shiftAmt      (shiftAmt),
		.aluSrcA       (aluSrcA),
		.aluSrcB       (aluSrcB),
		.aluOp         (aluOp),
		.pcSource      (pcSource),
		.shiftCtrl     (shiftCtrl),
		.regDst        (regDst),
		.memToReg      (memToReg)
	);

endmodule

// File: controlUnit_assert.sv
`timescale 1ns/100ps

module controlUnit_assert (
	input                            clock,
	input                            reset,
	input  logic                     pcWrite,
	input  logic                     regWrite,
	input  logic                     irWrite,
	input  controlPkg::controlStateT state
);

	import controlPkg::*;

	// One cycle never both moves the PC and writes a register
	pcRegExclusive: assert property (@(posedge clock) disable iff (reset)
		!(pcWrite && regWrite))
		else $error("pcWrite and regWrite high in the same cycle");

	idleReturns: assert property (@(posedge clock) disable iff (reset)
		(state == stIdle) |=> (state == stFetch))
		else $error("stIdle not followed by stFetch");

	irWriteStates: assert property (@(posedge clock) disable iff (reset)
		irWrite |-> (state == stWaitFetch2 || state == stDecode))
		else $error("irWrite high outside stWaitFetch2 and stDecode");

endmodule

bind controlUnit controlUnit_assert controlUnit_assert_inst (
	.clock    (clock),
	.reset    (reset),
	.pcWrite  (pcWrite),
	.regWrite (regWrite),
	.irWrite  (irWrite),
	.state    (state)
);

// File: controlUnitTb.sv
`timescale 1ns/100ps

module controlUnitTb;

	import controlPkg::*;

	typedef struct packed {
		logic pcWrite, regWrite, irWrite, writeRegA;
		logic writeRegB, aluOutControl, shiftSrc, shiftAmt;
		aluSrcAT aluSrcA;
		aluSrcBT aluSrcB;
		aluOpT aluOp;
		pcSourceT pcSource;
		shiftCtrlT shiftCtrl;
		regDstT regDst;
		memToRegT memToReg;
	} outputsT;

	localparam int fetchTimeout = 12;
	localparam int roundTimeout = 10;

	logic clock;
	logic reset;
	opcodeT opcode;
	functT funct;
	logic pcWrite, regWrite, irWrite, writeRegA;
	logic writeRegB, aluOutControl, shiftSrc, shiftAmt;
	aluSrcAT aluSrcA;
	aluSrcBT aluSrcB;
	aluOpT aluOp;
	pcSourceT pcSource;
	shiftCtrlT shiftCtrl;
	regDstT regDst;
	memToRegT memToReg;
	controlStateT state;

	opcodeT opcodeTable[$];
	functT functTable[$];
	instrClassT classTable[$];
	integer seed;

	controlUnit controlUnit_inst (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
			$display("*** FAILED ***");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "run aborted");
	endtask

	// Decoding rule for the random entries
	function automatic instrClassT classFromCodes(opcodeT op, functT fn);
		if (op == opAddi) return clsAddi;
		if (op == opAddiu) return clsAddiu;
		if (op == opLui) return clsLui;
		if (op != opRType) return clsUnsupported;
		if (fn == fnAdd) return clsAdd;
		if (fn == fnSub) return clsSub;
		if (fn == fnAnd) return clsAnd;
		if (fn == fnSrl) return clsSrl;
		if (fn == fnSra) return clsSra;
		if (fn == fnBreak) return clsBreak;
		return clsUnsupported;
	endfunction

	function automatic controlStateT stateAfter(controlStateT st, instrClassT cls);
		case (st)
			stFetch: return stWaitFetch;
			stWaitFetch: return stWaitFetch2;
			stWaitFetch2: return stDecode;
			stDecode: return stExecute;
			stExecute: begin
				if (cls == clsBreak) return stFetch;
				if (cls == clsLui || cls == clsUnsupported) return stIdle;
				return stWriteBack;
			end
			stWriteBack: return stIdle;
			default: return stFetch;
		endcase
	endfunction

	function automatic outputsT outputsFor(controlStateT st, instrClassT cls);
		outputsT o;
		o = '0;
		case (st)
			stFetch: begin
				o.pcWrite = 1'b1;
				o.aluSrcB = srcBFour;
				o.aluOp = aluAdd;
				o.pcSource = pcFromAlu;
				o.regDst = regDstRd;
			end
			stWaitFetch2: o.irWrite = 1'b1;
			stDecode: begin
				o.irWrite = 1'b1;
				o.writeRegA = 1'b1;
				o.writeRegB = 1'b1;
				o.aluOutControl = 1'b1;
				o.shiftSrc = 1'b1;
				o.aluSrcB = srcBBranch;
				o.aluOp = aluAdd;
				o.shiftCtrl = shiftLoad;
			end
			stExecute: begin
				case (cls)
					clsAddi: begin
						o.aluSrcA = srcARegA;
						o.aluSrcB = srcBImm;
						o.aluOp = aluAdd;
						o.aluOutControl = 1'b1;
						o.regDst = regDstImm;
					end
					clsAddiu: begin
						o.aluSrcA = srcARegA;
						o.aluSrcB = srcBImm;
						o.aluOp = aluAdd;
						o.aluOutControl = 1'b1;
						o.regDst = regDstRt;
					end
					clsAdd, clsSub, clsAnd: begin
						o.aluSrcA = srcARegA;
						o.aluSrcB = srcBRegB;
						o.aluOutControl = 1'b1;
						o.aluOp = (cls == clsAdd) ? aluAdd : (cls == clsSub) ? aluSub : aluAnd;
					end
					clsSrl, clsSra: begin
						o.shiftAmt = 1'b1;
						o.shiftCtrl = (cls == clsSrl) ? shiftRight : shiftArith;
					end
					clsLui: begin
						o.regWrite = 1'b1;
						o.regDst = regDstImm;
						o.memToReg = memToRegUpper;
					end
					clsBreak: begin
						o.pcWrite = 1'b1;
						o.aluSrcB = srcBFour;
						o.aluOp = aluSub;
						o.pcSource = pcFromAlu;
					end
				endcase
			end
			stWriteBack: begin
				// Only the write-back classes reach this state
				o.regWrite = 1'b1;
				o.regDst = (cls == clsAddi || cls == clsAddiu) ? regDstImm : regDstRd;
				o.memToReg = (cls == clsSrl || cls == clsSra) ? memToRegShift : memToRegAlu;
			end
		endcase
		return o;
	endfunction

	task automatic compareOutputs(input controlStateT expState, input instrClassT cls);
		outputsT o;
		o = outputsFor(expState, cls);
		checkValue("state", 32'(state), 32'(expState));
		checkValue("pcWrite", 32'(pcWrite), 32'(o.pcWrite));
		checkValue("regWrite", 32'(regWrite), 32'(o.regWrite));
		checkValue("irWrite", 32'(irWrite), 32'(o.irWrite));
		checkValue("writeRegA", 32'(writeRegA), 32'(o.writeRegA));
		checkValue("writeRegB", 32'(writeRegB), 32'(o.writeRegB));
		checkValue("aluOutControl", 32'(aluOutControl), 32'(o.aluOutControl));
		checkValue("shiftSrc", 32'(shiftSrc), 32'(o.shiftSrc));
		checkValue("shiftAmt", 32'(shiftAmt), 32'(o.shiftAmt));
		checkValue("aluSrcA", 32'(aluSrcA), 32'(o.aluSrcA));
		checkValue("aluSrcB", 32'(aluSrcB), 32'(o.aluSrcB));
		checkValue("aluOp", 32'(aluOp), 32'(o.aluOp));
		checkValue("pcSource", 32'(pcSource), 32'(o.pcSource));
		checkValue("shiftCtrl", 32'(shiftCtrl), 32'(o.shiftCtrl));
		checkValue("regDst", 32'(regDst), 32'(o.regDst));
		checkValue("memToReg", 32'(memToReg), 32'(o.memToReg));
	endtask

	task automatic waitForFetch();
		int count;
		count = 0;
		while (state !== stFetch) begin
			if (count == fetchTimeout) abortRun("Timed out waiting for the fetch state");
			count++;
			@(posedge clock);
			#10;
		end
	endtask

	task automatic runEntry(input opcodeT op, input functT fn, input instrClassT cls);
		controlStateT expState;
		int cycles;
		expState = stFetch;
		cycles = 0;
		waitForFetch();
		do begin
			// Codes turn to garbage once decode has latched the class
			opcode = (expState inside {stExecute, stWriteBack, stIdle}) ? op ^ 6'h3f : op;
			funct = (expState inside {stExecute, stWriteBack, stIdle}) ? fn ^ 6'h3f : fn;
			compareOutputs(expState, cls);
			expState = stateAfter(expState, cls);
			cycles++;
			if (cycles > roundTimeout) abortRun("Round did not return to the fetch state");
			@(posedge clock);
			#10;
		end while (state !== stFetch);
		checkValue("roundCycles", cycles,
			(cls == clsBreak) ? 5 : (cls == clsLui || cls == clsUnsupported) ? 6 : 7);
	endtask

	task automatic addEntry(input opcodeT op, input functT fn, input instrClassT cls);
		opcodeTable.push_back(op);
		functTable.push_back(fn);
		classTable.push_back(cls);
	endtask

	initial begin
		opcodeT randomOpcode;
		functT randomFunct;
		seed = 32'hd72d;
		reset = 1'b1;
		opcode = '0;
		funct = '0;
		addEntry(opAddi, 6'd0, clsAddi);
		addEntry(opAddiu, 6'd5, clsAddiu);
		addEntry(opLui, 6'h3f, clsLui);
		addEntry(opRType, fnAdd, clsAdd);
		addEntry(opRType, fnSub, clsSub);
		addEntry(opRType, fnAnd, clsAnd);
		addEntry(opRType, fnSrl, clsSrl);
		addEntry(opRType, fnSra, clsSra);
		addEntry(opRType, fnBreak, clsBreak);
		addEntry(6'd4, fnAdd, clsUnsupported);
		addEntry(6'd35, 6'd0, clsUnsupported);
		addEntry(opRType, 6'd24, clsUnsupported);
		// First two random entries stay R-type to exercise funct decoding
		for (int i = 0; i < 5; i++) begin
			randomOpcode = (i < 2) ? opRType : 6'($random(seed));
			randomFunct = 6'($random(seed));
			addEntry(randomOpcode, randomFunct, classFromCodes(randomOpcode, randomFunct));
		end
		repeat (2) @(posedge clock);
		#10;
		reset = 1'b0;
		foreach (opcodeTable[i]) begin
			runEntry(opcodeTable[i], functTable[i], classTable[i]);
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: sim.f
controlPkg.sv
instructionDecoder.sv
controlSequencer.sv
controlSignalTable.sv
controlUnit.sv
controlUnit_assert.sv
controlUnitTb.sv

// File: run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module controlUnitTb -f sim.f -o controlUnitSim
./obj_dir/controlUnitSim
